/* common/memory_game_consts.svh */
// Memory game constants for sequence length and timer limits

`ifndef MEMORY_GAME_CONSTS_SVH
`define MEMORY_GAME_CONSTS_SVH

// Entries in the fixed sequence
`define SEQ_LEN 16

// Cycles allowed in wait_move before timeout
`define MOVE_TIMEOUT 200
`define MOVE_TIMEOUT_W 8

// Cycles the newest element stays lit
`define LED_SHOW 4
`define LED_SHOW_W 3

`endif

/* common/memory_game_pkg.sv */
// Memory game package with the FSM state type and the sequence index type

`include "memory_game_consts.svh"

package memory_game_pkg;

    // ----------------------------------------------------------
    // Control FSM states
    // ----------------------------------------------------------
    // The encoding is shown on the state display, so end states use letters
    typedef enum logic [3:0] {
        st_idle       = 4'h0,
        st_init       = 4'h1,
        st_show       = 4'h2,
        st_wait_move  = 4'h3,
        st_check      = 4'h4,
        st_next_move  = 4'h5,
        st_next_round = 4'h6,
        st_won        = 4'hA,
        st_lost       = 4'hE,
        st_timed_out  = 4'hF
    } game_state_t;

    // Index into the sequence, used for the address and the round
    typedef logic [$clog2(`SEQ_LEN)-1:0] seq_idx_t;

endpackage

/* common/game_ctrl_if.sv */
// Control bus between the game FSM and the datapath blocks

`timescale 1ns/10ps

interface game_ctrl_if;
    import memory_game_pkg::*;

    // Strobes from the FSM
    logic clear_addr;
    logic count_addr;
    logic clear_round;
    logic count_round;
    logic clear_move;
    logic load_move;
    logic clear_timer;
    logic count_timer;
    logic start_show;

    // Status levels from the datapath
    logic addr_end;
    logic last_round;
    logic move_seen;
    logic move_ok;
    logic timer_expired;
    logic show_done;

    // Shared between datapath blocks
    seq_idx_t   address;
    logic [3:0] rom_word;

    modport ctrl (
        output clear_addr, count_addr, clear_round, count_round,
        output clear_move, load_move, clear_timer, count_timer, start_show,
        input  addr_end, last_round, move_seen, move_ok, timer_expired, show_done
    );

    modport dp (
        input  clear_addr, count_addr, clear_round, count_round,
        input  clear_move, load_move, clear_timer, count_timer, start_show,
        output addr_end, last_round, move_seen, move_ok, timer_expired, show_done,
        output address, rom_word
    );

endinterface

/* datapath/sequence_rom.sv */
// Fixed sequence table of one-hot button codes

`timescale 1ns/10ps
`include "memory_game_consts.svh"

module sequence_rom (
    game_ctrl_if.dp                   dp,
    input  memory_game_pkg::seq_idx_t round,
    output logic [3:0]                word,
    output logic [3:0]                show_word
);

    // Lit button number per entry
    localparam logic [1:0] LIT_BIT [`SEQ_LEN] = '{
        2'd0, 2'd1, 2'd2, 2'd3,
        2'd2, 2'd1, 2'd3, 2'd0,
        2'd1, 2'd3, 2'd2, 2'd0,
        2'd3, 2'd2, 2'd1, 2'd0
    };

    // Entry under test during replay
    assign word = 4'b0001 << LIT_BIT[dp.address];

    // Newest entry of the round, shown on the LEDs
    assign show_word = 4'b0001 << LIT_BIT[round];

    assign dp.rom_word = word;

endmodule

/* datapath/round_counters.sv */
// Address and round counters with end-of-round and last-round flags

`timescale 1ns/10ps
`include "memory_game_consts.svh"

module round_counters (
    input  logic                      clock,
    input  logic                      arst_n,
    game_ctrl_if.dp                   dp,
    output memory_game_pkg::seq_idx_t round
);
    import memory_game_pkg::*;

    seq_idx_t addr_q;
    seq_idx_t round_q;

    // Address within the current round
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            addr_q <= '0;
        end else if (dp.clear_addr) begin
            addr_q <= '0;
        end else if (dp.count_addr) begin
            addr_q <= addr_q + 1'b1;
        end
    end

    // Index of the newest entry in play
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            round_q <= '0;
        end else if (dp.clear_round) begin
            round_q <= '0;
        end else if (dp.count_round) begin
            round_q <= round_q + 1'b1;
        end
    end

    assign dp.address    = addr_q;
    assign dp.addr_end   = (addr_q == round_q);
    assign dp.last_round = (round_q == seq_idx_t'(`SEQ_LEN - 1));
    assign round         = round_q;

endmodule

/* datapath/move_register.sv */
// Button press detection, move register and comparison against the sequence

`timescale 1ns/10ps

module move_register (
    input  logic       clock,
    input  logic       arst_n,
    input  logic [3:0] buttons,
    game_ctrl_if.dp    dp,
    output logic [3:0] move
);

    logic [3:0] prev_buttons;
    logic       press;
    logic       seen;

    // New press is a change from all released to any pressed
    assign press = (buttons != 4'b0000) && (prev_buttons == 4'b0000);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            prev_buttons <= 4'b0000;
            seen         <= 1'b0;
            move         <= 4'b0000;
        end else begin
            prev_buttons <= buttons;
            if (dp.clear_move) begin
                seen <= 1'b0;
                move <= 4'b0000;
            end else if (dp.load_move && press) begin
                seen <= 1'b1;
                move <= buttons;
            end
        end
    end

    assign dp.move_seen = seen;

    // Exact match, so two buttons together never pass
    assign dp.move_ok = (move == dp.rom_word);

endmodule

/* datapath/play_timer.sv */
// Move timeout counter and LED show counter

`timescale 1ns/10ps
`include "memory_game_consts.svh"

module play_timer (
    input  logic    clock,
    input  logic    arst_n,
    game_ctrl_if.dp dp
);

    logic [`MOVE_TIMEOUT_W-1:0] move_cnt;
    logic [`LED_SHOW_W-1:0]     show_cnt;

    // ----------------------------------------------------------
    // Cycles spent waiting for a press
    // ----------------------------------------------------------
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            move_cnt <= '0;
        end else if (dp.clear_timer) begin
            move_cnt <= '0;
        end else if (dp.count_timer) begin
            move_cnt <= move_cnt + 1'b1;
        end
    end

    // Last allowed cycle, FSM leaves on the next edge
    assign dp.timer_expired = (move_cnt == `MOVE_TIMEOUT_W'(`MOVE_TIMEOUT - 1));

    // ----------------------------------------------------------
    // LED show length, holds at the limit
    // ----------------------------------------------------------
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            show_cnt <= '0;
        end else if (dp.start_show) begin
            show_cnt <= `LED_SHOW_W'(1);
        end else if (show_cnt != '0 && show_cnt != `LED_SHOW_W'(`LED_SHOW)) begin
            show_cnt <= show_cnt + 1'b1;
        end
    end

    assign dp.show_done = (show_cnt == `LED_SHOW_W'(`LED_SHOW));

endmodule

/* src/hex7seg.sv */
// Hex digit to seven-segment decoder with active-high segments

`timescale 1ns/10ps

module hex7seg (
    input  logic [3:0] hexa,
    output logic [6:0] display
);

    // Bit order is g f e d c b a
    always_comb begin
        case (hexa)
            4'h0:    display = 7'h3F;
            4'h1:    display = 7'h06;
            4'h2:    display = 7'h5B;
            4'h3:    display = 7'h4F;
            4'h4:    display = 7'h66;
            4'h5:    display = 7'h6D;
            4'h6:    display = 7'h7D;
            4'h7:    display = 7'h07;
            4'h8:    display = 7'h7F;
            4'h9:    display = 7'h6F;
            4'hA:    display = 7'h77;
            4'hB:    display = 7'h7C;
            4'hC:    display = 7'h39;
            4'hD:    display = 7'h5E;
            4'hE:    display = 7'h79;
            default: display = 7'h71;
        endcase
    end

endmodule

/* src/game_fsm.sv */
// Game control FSM sequencing rounds and deciding win, loss and timeout

`timescale 1ns/10ps

module game_fsm (
    input  logic                        clock,
    input  logic                        arst_n,
    input  logic                        play,
    game_ctrl_if.ctrl                   ctrl,
    output logic                        won,
    output logic                        lost,
    output logic                        timeout,
    output logic                        ready,
    output memory_game_pkg::game_state_t state
);
    import memory_game_pkg::*;

    game_state_t next_state;

    // ----------------------------------------------------------
    // State register
    // ----------------------------------------------------------
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    // ----------------------------------------------------------
    // Next state
    // ----------------------------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            st_idle, st_won, st_lost, st_timed_out: begin
                if (play) begin
                    next_state = st_init;
                end
            end
            st_init:       next_state = st_show;
            st_show: begin
                if (ctrl.show_done) begin
                    next_state = st_wait_move;
                end
            end
            st_wait_move: begin
                // A press seen in the same cycle as expiry still counts
                if (ctrl.move_seen) begin
                    next_state = st_check;
                end else if (ctrl.timer_expired) begin
                    next_state = st_timed_out;
                end
            end
            st_check: begin
                if (!ctrl.move_ok) begin
                    next_state = st_lost;
                end else if (!ctrl.addr_end) begin
                    next_state = st_next_move;
                end else if (ctrl.last_round) begin
                    next_state = st_won;
                end else begin
                    next_state = st_next_round;
                end
            end
            st_next_move:  next_state = st_wait_move;
            st_next_round: next_state = st_show;
            default:       next_state = st_idle;
        endcase
    end

    // ----------------------------------------------------------
    // Moore outputs
    // ----------------------------------------------------------
    always_comb begin
        ctrl.clear_addr  = 1'b0;
        ctrl.count_addr  = 1'b0;
        ctrl.clear_round = 1'b0;
        ctrl.count_round = 1'b0;
        ctrl.clear_move  = 1'b0;
        ctrl.load_move   = 1'b0;
        ctrl.clear_timer = 1'b0;
        ctrl.count_timer = 1'b0;
        ctrl.start_show  = 1'b0;
        case (state)
            st_init: begin
                ctrl.clear_addr  = 1'b1;
                ctrl.clear_round = 1'b1;
                ctrl.clear_move  = 1'b1;
                ctrl.clear_timer = 1'b1;
                ctrl.start_show  = 1'b1;
            end
            st_wait_move: begin
                ctrl.load_move   = 1'b1;
                ctrl.count_timer = 1'b1;
            end
            st_next_move: begin
                ctrl.count_addr  = 1'b1;
                ctrl.clear_move  = 1'b1;
                ctrl.clear_timer = 1'b1;
            end
            st_next_round: begin
                // Round grows by one, replay starts from entry zero
                ctrl.count_round = 1'b1;
                ctrl.clear_addr  = 1'b1;
                ctrl.clear_move  = 1'b1;
                ctrl.clear_timer = 1'b1;
                ctrl.start_show  = 1'b1;
            end
            default: ;
        endcase
    end

    assign won     = (state == st_won);
    assign lost    = (state == st_lost);
    assign timeout = (state == st_timed_out);
    assign ready   = (state == st_idle) || won || lost || timeout;

endmodule

/* src/memory_game.sv */
// Memory game top level joining the control FSM, datapath and debug displays

`timescale 1ns/10ps

module memory_game (
    input  logic       clock,
    input  logic       arst_n,
    input  logic       play,
    input  logic [3:0] buttons,
    output logic       won,
    output logic       lost,
    output logic       timeout,
    output logic       ready,
    output logic [3:0] leds,
    output logic [6:0] db_address,
    output logic [6:0] db_round,
    output logic [6:0] db_memory,
    output logic [6:0] db_move,
    output logic [6:0] db_state,
    output logic       db_move_ok
);
    import memory_game_pkg::*;

    game_state_t state;
    seq_idx_t    round;
    logic [3:0]  word;
    logic [3:0]  show_word;
    logic [3:0]  move;

    game_ctrl_if game_bus ();

    // ----------------------------------------------------------
    // Control and datapath
    // ----------------------------------------------------------
    game_fsm fsm_inst (
        .clock   ( clock    ),
        .arst_n  ( arst_n   ),
        .play    ( play     ),
        .ctrl    ( game_bus ),
        .won     ( won      ),
        .lost    ( lost     ),
        .timeout ( timeout  ),
        .ready   ( ready    ),
        .state   ( state    )
    );

    sequence_rom rom_inst (
        .dp        ( game_bus  ),
        .round     ( round     ),
        .word      ( word      ),
        .show_word ( show_word )
    );

    round_counters counters_inst (
        .clock  ( clock    ),
        .arst_n ( arst_n   ),
        .dp     ( game_bus ),
        .round  ( round    )
    );

    move_register move_inst (
        .clock   ( clock    ),
        .arst_n  ( arst_n   ),
        .buttons ( buttons  ),
        .dp      ( game_bus ),
        .move    ( move     )
    );

    play_timer timer_inst (
        .clock  ( clock    ),
        .arst_n ( arst_n   ),
        .dp     ( game_bus )
    );

    // LEDs lit only while the newest entry is on show
    assign leds       = (state == st_show) ? show_word : 4'b0000;
    assign db_move_ok = game_bus.move_ok;

    // ----------------------------------------------------------
    // Debug displays
    // ----------------------------------------------------------
    hex7seg hex_address ( .hexa ( game_bus.address ), .display ( db_address ) );
    hex7seg hex_round   ( .hexa ( round            ), .display ( db_round   ) );
    hex7seg hex_memory  ( .hexa ( word             ), .display ( db_memory  ) );
    hex7seg hex_move    ( .hexa ( move             ), .display ( db_move    ) );
    hex7seg hex_state   ( .hexa ( state            ), .display ( db_state   ) );

endmodule

/* dv/memory_game_checker.sv */
// Memory game output checker for end flags, ready and LED patterns

`timescale 1ns/10ps

module memory_game_checker (
    input logic       clock,
    input logic       arst_n,
    input logic       won,
    input logic       lost,
    input logic       timeout,
    input logic       ready,
    input logic [3:0] leds
);

    // Count of failed assertions
    int unsigned failures = 0;

    // At most one way to end a game
    end_flags_exclusive: assert property (
        @(posedge clock) disable iff (!arst_n) $onehot0({won, lost, timeout})
    ) else begin
        failures++;
        $error("won, lost and timeout are high together");
    end

    // One entry lit at a time
    leds_one_hot: assert property (
        @(posedge clock) disable iff (!arst_n) $onehot0(leds)
    ) else begin
        failures++;
        $error("leds show more than one button");
    end

    end_means_ready: assert property (
        @(posedge clock) disable iff (!arst_n) (won || lost || timeout) |-> ready
    ) else begin
        failures++;
        $error("end flag high while ready is low");
    end

endmodule

/* dv/memory_game_tb.sv */
// Memory game testbench driving table rows of rounds with win, loss and timeout endings

`timescale 1ns/10ps
`include "memory_game_consts.svh"

module memory_game_tb;

    // Ending kinds of a row
    localparam logic [1:0] END_WIN    = 2'd0;
    localparam logic [1:0] END_WRONG  = 2'd1;
    localparam logic [1:0] END_DOUBLE = 2'd2;
    localparam logic [1:0] END_NONE   = 2'd3;

    localparam int NUM_ROWS = 8;
    localparam int MAX_GAP  = 10;
    localparam int HOLD     = 4;

    // Worst row is sixteen full rounds with the longest gaps, plus a timeout
    localparam int ROW_BUDGET = (`SEQ_LEN * (`SEQ_LEN + 1) / 2) * (MAX_GAP + HOLD + 1)
                              + `SEQ_LEN * (`LED_SHOW + 8) + `MOVE_TIMEOUT;
    localparam int CYCLE_LIMIT = 16 + NUM_ROWS * ROW_BUDGET + 500;

    typedef struct packed {
        logic [4:0] rounds;
        logic [1:0] ending;
        logic       exp_won;
        logic       exp_lost;
        logic       exp_timeout;
    } row_t;

    // Correct rounds played first, then the ending in the next round
    localparam row_t TEST_TABLE [NUM_ROWS] = '{
        '{5'd16, END_WIN,    1'b1, 1'b0, 1'b0},
        '{5'd0,  END_WRONG,  1'b0, 1'b1, 1'b0},
        '{5'd4,  END_WRONG,  1'b0, 1'b1, 1'b0},
        '{5'd11, END_WRONG,  1'b0, 1'b1, 1'b0},
        '{5'd3,  END_DOUBLE, 1'b0, 1'b1, 1'b0},
        '{5'd0,  END_NONE,   1'b0, 1'b0, 1'b1},
        '{5'd6,  END_NONE,   1'b0, 1'b0, 1'b1},
        '{5'd2,  END_WRONG,  1'b0, 1'b1, 1'b0}
    };

    // One-hot button code per sequence entry
    localparam logic [3:0] SEQ_CODE [`SEQ_LEN] = '{
        4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0100, 4'b0010, 4'b1000, 4'b0001,
        4'b0010, 4'b1000, 4'b0100, 4'b0001, 4'b1000, 4'b0100, 4'b0010, 4'b0001
    };

    // Active-high segments g to a for hex digits 0 to F
    localparam logic [6:0] SEG_CODE [16] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
        7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
    };

    // State display digits, following the order of the state list
    localparam logic [3:0] STATE_IDLE  = 4'd0;
    localparam logic [3:0] STATE_SHOW  = 4'd2;
    localparam logic [3:0] STATE_CHECK = 4'd4;

    logic       clock = 1'b0;
    logic       arst_n;
    logic       play;
    logic [3:0] buttons;
    logic       won;
    logic       lost;
    logic       timeout;
    logic       ready;
    logic [3:0] leds;
    logic [6:0] db_address;
    logic [6:0] db_round;
    logic [6:0] db_memory;
    logic [6:0] db_move;
    logic [6:0] db_state;
    logic       db_move_ok;

    int errors      = 0;
    int row_errors  = 0;
    int rows_failed = 0;
    int cycle_count = 0;

    memory_game memory_game_inst (
        .clock      ( clock      ),
        .arst_n     ( arst_n     ),
        .play       ( play       ),
        .buttons    ( buttons    ),
        .won        ( won        ),
        .lost       ( lost       ),
        .timeout    ( timeout    ),
        .ready      ( ready      ),
        .leds       ( leds       ),
        .db_address ( db_address ),
        .db_round   ( db_round   ),
        .db_memory  ( db_memory  ),
        .db_move    ( db_move    ),
        .db_state   ( db_state   ),
        .db_move_ok ( db_move_ok )
    );

    bind memory_game memory_game_checker checker_inst (
        .clock   ( clock   ),
        .arst_n  ( arst_n  ),
        .won     ( won     ),
        .lost    ( lost    ),
        .timeout ( timeout ),
        .ready   ( ready   ),
        .leds    ( leds    )
    );

    always #4 clock = ~clock;

    // Run limit
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles, the game never finished", cycle_count);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------
    function automatic logic [3:0] expected_code(input int idx);
        expected_code = SEQ_CODE[idx];
    endfunction

    function automatic logic [6:0] seg_code(input logic [3:0] digit);
        seg_code = SEG_CODE[digit];
    endfunction

    // Neighbouring button, wraps from 3 to 0
    function automatic logic [3:0] next_button(input logic [3:0] code);
        next_button = {code[2:0], code[3]};
    endfunction

    function automatic string ending_name(input logic [1:0] ending);
        case (ending)
            END_WIN:    ending_name = "win";
            END_WRONG:  ending_name = "wrong press";
            END_DOUBLE: ending_name = "double press";
            default:    ending_name = "no press";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Fail at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
            errors++;
            row_errors++;
        end
    endtask

    task automatic report_problem(input string what);
        $display("Error at %0t ns: %s", $time, what);
        errors++;
        row_errors++;
    endtask

    task automatic start_game();
        @(posedge clock);
        play <= 1'b1;
        @(posedge clock);
        play <= 1'b0;
        @(negedge clock);
        check_value("ready", ready, 0);
        check_value("won", won, 0);
        check_value("lost", lost, 0);
        check_value("timeout", timeout, 0);
    endtask

    // Newest entry must stay lit for exactly the show time
    task automatic watch_show(input int round);
        int waited;
        int lit;
        waited = 0;
        lit = 0;
        while (leds == 4'b0000 && waited < 20) begin
            waited++;
            @(negedge clock);
        end
        assert (leds != 4'b0000) else begin
            report_problem($sformatf("leds never lit for round %0d", round));
        end
        check_value("db_round", db_round, seg_code(round));
        check_value("db_state", db_state, seg_code(STATE_SHOW));
        while (leds != 4'b0000 && lit < 2 * `LED_SHOW) begin
            check_value("leds", leds, expected_code(round));
            lit++;
            @(negedge clock);
        end
        check_value("show cycles", lit, `LED_SHOW);
    endtask

    // Held long enough for seen, check and the following state
    task automatic press_button(input logic [3:0] code, input int addr);
        int gap;
        gap = 1 + ($urandom % MAX_GAP);
        repeat (gap) @(posedge clock);
        buttons <= code;
        repeat (2) @(posedge clock);
        // Move registered, game now in check
        @(negedge clock);
        check_value("db_state", db_state, seg_code(STATE_CHECK));
        check_value("db_address", db_address, seg_code(addr));
        check_value("db_memory", db_memory, seg_code(expected_code(addr)));
        check_value("db_move", db_move, seg_code(code));
        check_value("db_move_ok", db_move_ok, code == expected_code(addr));
        repeat (HOLD - 2) @(posedge clock);
        buttons <= 4'b0000;
        @(negedge clock);
    endtask

    task automatic check_ending(input row_t row);
        int waited;
        waited = 0;
        while (!ready && waited < 20) begin
            waited++;
            @(negedge clock);
        end
        assert (ready) else begin
            report_problem("game did not reach an end state");
        end
        check_value("won", won, row.exp_won);
        check_value("lost", lost, row.exp_lost);
        check_value("timeout", timeout, row.exp_timeout);
        check_value("ready", ready, 1);
    endtask

    task automatic run_row(input row_t row);
        int r;
        int a;
        int idle_cycles;
        start_game();
        for (r = 0; r < row.rounds; r++) begin
            watch_show(r);
            for (a = 0; a <= r; a++) begin
                press_button(expected_code(a), a);
            end
        end
        if (row.ending != END_WIN) begin
            watch_show(row.rounds);
        end
        if (row.ending == END_WRONG || row.ending == END_DOUBLE) begin
            for (a = 0; a < row.rounds; a++) begin
                press_button(expected_code(a), a);
            end
        end
        case (row.ending)
            END_WRONG: begin
                press_button(next_button(expected_code(row.rounds)), row.rounds);
            end
            END_DOUBLE: begin
                press_button(expected_code(row.rounds) |
                             next_button(expected_code(row.rounds)), row.rounds);
            end
            END_NONE: begin
                // Counting starts in the first wait_move cycle
                idle_cycles = 0;
                while (!timeout && idle_cycles < `MOVE_TIMEOUT + 20) begin
                    idle_cycles++;
                    @(negedge clock);
                end
                check_value("timeout cycles", idle_cycles, `MOVE_TIMEOUT);
            end
            default: ;
        endcase
        check_ending(row);
    endtask

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin
        int i;
        void'($urandom(32'hca37));
        arst_n  = 1'b0;
        play    = 1'b0;
        buttons = 4'b0000;
        repeat (16) @(posedge clock);
        arst_n <= 1'b1;
        @(negedge clock);

        row_errors = 0;
        check_value("ready", ready, 1);
        check_value("leds", leds, 0);
        check_value("won", won, 0);
        check_value("lost", lost, 0);
        check_value("timeout", timeout, 0);
        check_value("db_state", db_state, seg_code(STATE_IDLE));
        check_value("db_address", db_address, seg_code(4'd0));
        check_value("db_round", db_round, seg_code(4'd0));
        check_value("db_memory", db_memory, seg_code(expected_code(0)));
        check_value("db_move", db_move, seg_code(4'd0));
        check_value("db_move_ok", db_move_ok, 0);
        $display("Test reset state: %s", row_errors == 0 ? "ok" : "failed");
        if (row_errors != 0) begin
            rows_failed++;
        end

        for (i = 0; i < NUM_ROWS; i++) begin
            row_errors = 0;
            run_row(TEST_TABLE[i]);
            if (row_errors != 0) begin
                rows_failed++;
            end
            $display("Test %0d, %s after %0d rounds: %s", i,
                     ending_name(TEST_TABLE[i].ending), TEST_TABLE[i].rounds,
                     row_errors == 0 ? "ok" : "failed");
        end

        $display("Tests run %0d, tests failed %0d, checks failed %0d, assertion failures %0d",
                 NUM_ROWS + 1, rows_failed, errors, memory_game_inst.checker_inst.failures);
        if (errors == 0 && memory_game_inst.checker_inst.failures == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+common
common/memory_game_pkg.sv
common/game_ctrl_if.sv
datapath/sequence_rom.sv
datapath/round_counters.sv
datapath/move_register.sv
datapath/play_timer.sv
src/hex7seg.sv
src/game_fsm.sv
src/memory_game.sv
dv/memory_game_checker.sv
dv/memory_game_tb.sv

/* Makefile */
# Verilator simulation of the memory game

.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal -f sim.f --top-module memory_game_tb -o memory_game_sim
	@out="$$(./obj_dir/memory_game_sim +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
